// ==== include/wb_thresholds_settings.svh ====
`ifndef WB_THRESHOLDS_SETTINGS_SVH
`define WB_THRESHOLDS_SETTINGS_SVH

// trigger channels served by the register block
`define TH_NUM_CHAN 2

// threshold slots per channel that stream in order 0 to 3
`define TH_NUM_SLOT 4

`define TH_WIDTH 18

// scaler timer period width and its value after reset
`define TH_PERIOD_WIDTH 24
`define TH_DEFAULT_PERIOD 100

`endif

// ==== design/th_types_pkg.sv ====
`include "wb_thresholds_settings.svh"

package th_types_pkg;

    ////////////////////////////////////////////////////////////
    // threshold datapath
    ////////////////////////////////////////////////////////////

    typedef logic [`TH_WIDTH-1:0] threshold_t;

    typedef logic [$clog2(`TH_NUM_CHAN)-1:0] chan_idx_t;
    typedef logic [$clog2(`TH_NUM_SLOT)-1:0] slot_idx_t;

    // one bit per channel for requests, strobes and status
    typedef logic [`TH_NUM_CHAN-1:0] chan_mask_t;

    typedef logic [`TH_PERIOD_WIDTH-1:0] period_t;

    // commit sequencer states
    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        COMMIT
    } seq_state_t;

endpackage

// ==== design/wb_map_pkg.sv ====
package wb_map_pkg;

    ////////////////////////////////////////////////////////////
    // bus word types
    ////////////////////////////////////////////////////////////

    typedef logic [11:0] wb_adr_t;
    typedef logic [31:0] wb_data_t;

    ////////////////////////////////////////////////////////////
    // address fields
    ////////////////////////////////////////////////////////////

    // set for the control region, clear for the threshold region
    localparam int ADR_REGION_BIT = 11;
    localparam int ADR_CHAN_BIT = 9;
    localparam int ADR_SLOT_LSB = 2;

    // control registers
    localparam wb_adr_t CTRL_UPDATE = 12'h800;
    localparam wb_adr_t CTRL_STATUS = 12'h804;
    localparam wb_adr_t CTRL_PERIOD = 12'h808;

endpackage

// ==== design/wb_reg_decoder.sv ====
`timescale 1ns/1ps
`include "wb_thresholds_settings.svh"

module wb_reg_decoder (
    input  logic                     wb_clk,
    input  logic                     rst_n_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  wb_map_pkg::wb_adr_t      wb_adr_i,
    input  wb_map_pkg::wb_data_t     wb_dat_i,
    output wb_map_pkg::wb_data_t     wb_dat_o,
    output logic                     wb_ack_o,
    output logic                     th_we_o,
    output th_types_pkg::chan_idx_t  th_chan_o,
    output th_types_pkg::slot_idx_t  th_slot_o,
    output th_types_pkg::threshold_t th_wdata_o,
    input  th_types_pkg::threshold_t th_rdata_i,
    output th_types_pkg::chan_mask_t upd_req_o,
    input  th_types_pkg::chan_mask_t busy_mask_i,
    output logic                     period_we_o,
    output th_types_pkg::period_t    period_wdata_o,
    input  th_types_pkg::period_t    period_i
);
    import th_types_pkg::*;
    import wb_map_pkg::*;

    logic     access;
    logic     wr_access;
    logic     ctrl_region;
    wb_data_t rd_word;

    // a new cycle is one that has not been acknowledged yet
    assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_access = access & wb_we_i;
    assign ctrl_region = wb_adr_i[ADR_REGION_BIT];

    assign th_chan_o = wb_adr_i[ADR_CHAN_BIT];
    assign th_slot_o = wb_adr_i[ADR_SLOT_LSB +: $bits(slot_idx_t)];

    ////////////////////////////////////////////////////////////
    // write strobes take effect on the edge that raises the ack
    ////////////////////////////////////////////////////////////

    assign th_we_o = wr_access & ~ctrl_region;
    assign th_wdata_o = wb_dat_i[`TH_WIDTH-1:0];

    assign upd_req_o = (wr_access && wb_adr_i == CTRL_UPDATE) ?
                       wb_dat_i[`TH_NUM_CHAN-1:0] : '0;

    assign period_we_o = wr_access && wb_adr_i == CTRL_PERIOD;
    assign period_wdata_o = wb_dat_i[`TH_PERIOD_WIDTH-1:0];

    ////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_word = '0;
        if (!ctrl_region) begin
            rd_word = wb_data_t'(th_rdata_i);
        end else if (wb_adr_i == CTRL_STATUS) begin
            rd_word = wb_data_t'(busy_mask_i);
        end else if (wb_adr_i == CTRL_PERIOD) begin
            rd_word = wb_data_t'(period_i);
        end
    end

    always_ff @(posedge wb_clk) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    // read word is captured with the ack and held through the ack cycle
    always_ff @(posedge wb_clk) begin
        if (access) begin
            wb_dat_o <= rd_word;
        end
    end

endmodule

// ==== design/threshold_bank.sv ====
`timescale 1ns/1ps
`include "wb_thresholds_settings.svh"

module threshold_bank (
    input  logic                     wb_clk,
    input  logic                     rst_n_i,
    input  logic                     we_i,
    input  th_types_pkg::chan_idx_t  wr_chan_i,
    input  th_types_pkg::slot_idx_t  wr_slot_i,
    input  th_types_pkg::threshold_t wdata_i,
    input  th_types_pkg::chan_idx_t  bus_chan_i,
    input  th_types_pkg::slot_idx_t  bus_slot_i,
    output th_types_pkg::threshold_t bus_rdata_o,
    input  th_types_pkg::chan_idx_t  rd_chan_i,
    input  th_types_pkg::slot_idx_t  rd_slot_i,
    output th_types_pkg::threshold_t rd_data_o
);
    import th_types_pkg::*;

    threshold_t mem_q [`TH_NUM_CHAN][`TH_NUM_SLOT];

    // a single write port serves all eight slots
    always_ff @(posedge wb_clk) begin
        if (!rst_n_i) begin
            for (int c = 0; c < `TH_NUM_CHAN; c++) begin
                for (int s = 0; s < `TH_NUM_SLOT; s++) begin
                    mem_q[c][s] <= '0;
                end
            end
        end else if (we_i) begin
            mem_q[wr_chan_i][wr_slot_i] <= wdata_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    // bus readback
    assign bus_rdata_o = mem_q[bus_chan_i][bus_slot_i];

    // sequencer reads live contents while it streams
    assign rd_data_o = mem_q[rd_chan_i][rd_slot_i];

endmodule

// ==== design/update_sequencer.sv ====
`timescale 1ns/1ps
`include "wb_thresholds_settings.svh"

module update_sequencer (
    input  logic                                       wb_clk,
    input  logic                                       rst_n_i,
    input  th_types_pkg::chan_mask_t                   upd_req_i,
    output th_types_pkg::chan_idx_t                    rd_chan_o,
    output th_types_pkg::slot_idx_t                    rd_slot_o,
    input  th_types_pkg::threshold_t                   rd_data_i,
    output th_types_pkg::chan_mask_t                   busy_mask_o,
    output th_types_pkg::threshold_t [`TH_NUM_CHAN-1:0] thresh_o,
    output th_types_pkg::chan_mask_t                   thresh_wr_o,
    output th_types_pkg::chan_mask_t                   thresh_update_o
);
    import th_types_pkg::*;

    seq_state_t                       state_q;
    chan_mask_t                       pending_q;
    chan_idx_t                        act_chan_q;
    slot_idx_t                        slot_q;
    chan_mask_t                       thresh_wr_q;
    chan_mask_t                       thresh_update_q;
    threshold_t [`TH_NUM_CHAN-1:0]    thresh_q;
    chan_mask_t                       active_mask;
    chan_idx_t                        pick_chan;
    chan_mask_t                       pick_mask;

    always_comb begin
        active_mask = '0;
        if (state_q != IDLE) begin
            active_mask[act_chan_q] = 1'b1;
        end
    end

    // lowest pending channel wins, so scan from the top down
    always_comb begin
        pick_chan = '0;
        pick_mask = '0;
        for (int i = `TH_NUM_CHAN - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                pick_chan = chan_idx_t'(i);
            end
        end
        pick_mask[pick_chan] = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // commit FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk) begin
        if (!rst_n_i) begin
            state_q         <= IDLE;
            pending_q       <= '0;
            act_chan_q      <= '0;
            slot_q          <= '0;
            thresh_wr_q     <= '0;
            thresh_update_q <= '0;
        end else begin
            thresh_wr_q     <= '0;
            thresh_update_q <= '0;
            // a request for the channel in flight merges with it
            pending_q <= pending_q | (upd_req_i & ~active_mask);
            case (state_q)
                IDLE: begin
                    if (|pending_q) begin
                        state_q    <= STREAM;
                        act_chan_q <= pick_chan;
                        slot_q     <= '0;
                        pending_q  <= (pending_q | upd_req_i) & ~pick_mask;
                    end
                end
                STREAM: begin
                    thresh_wr_q[act_chan_q] <= 1'b1;
                    slot_q <= slot_q + 1'b1;
                    if (slot_q == slot_idx_t'(`TH_NUM_SLOT - 1)) begin
                        state_q <= COMMIT;
                    end
                end
                COMMIT: begin
                    thresh_update_q[act_chan_q] <= 1'b1;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk) begin
        if (state_q == STREAM) begin
            thresh_q[act_chan_q] <= rd_data_i;
        end
    end

    assign rd_chan_o       = act_chan_q;
    assign rd_slot_o       = slot_q;
    assign busy_mask_o     = pending_q | active_mask;
    assign thresh_o        = thresh_q;
    assign thresh_wr_o     = thresh_wr_q;
    assign thresh_update_o = thresh_update_q;

endmodule

// ==== design/scaler_timer.sv ====
`timescale 1ns/1ps
`include "wb_thresholds_settings.svh"

module scaler_timer (
    input  logic                  wb_clk,
    input  logic                  rst_n_i,
    input  logic                  period_we_i,
    input  th_types_pkg::period_t period_wdata_i,
    output th_types_pkg::period_t period_o,
    output logic                  scal_tick_o,
    output logic                  scal_rst_o
);
    import th_types_pkg::*;

    period_t period_q;
    period_t cnt_q;
    logic    tick_q;
    logic    scal_rst_q;
    logic    wrap;

    assign wrap = cnt_q == period_t'(period_q - period_t'(1));

    ////////////////////////////////////////////////////////////
    // period register and tick counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge wb_clk) begin
        if (!rst_n_i) begin
            period_q   <= period_t'(`TH_DEFAULT_PERIOD);
            cnt_q      <= '0;
            tick_q     <= 1'b0;
            scal_rst_q <= 1'b0;
        end else begin
            scal_rst_q <= period_we_i;
            if (period_we_i) begin
                // a new period restarts the count and the first tick comes a full period later
                period_q <= period_wdata_i;
                cnt_q    <= '0;
                tick_q   <= 1'b0;
            end else begin
                tick_q <= wrap;
                cnt_q  <= wrap ? '0 : cnt_q + 1'b1;
            end
        end
    end

    assign period_o    = period_q;
    assign scal_tick_o = tick_q;
    assign scal_rst_o  = scal_rst_q;

endmodule

// ==== design/wb_thresholds.sv ====
`timescale 1ns/1ps
`include "wb_thresholds_settings.svh"

module wb_thresholds (
    input  logic                                       wb_clk,
    input  logic                                       rst_n_i,
    input  logic                                       wb_cyc_i,
    input  logic                                       wb_stb_i,
    input  logic                                       wb_we_i,
    input  wb_map_pkg::wb_adr_t                        wb_adr_i,
    input  wb_map_pkg::wb_data_t                       wb_dat_i,
    output wb_map_pkg::wb_data_t                       wb_dat_o,
    output logic                                       wb_ack_o,
    output logic                                       scal_tick_o,
    output logic                                       scal_rst_o,
    output th_types_pkg::threshold_t [`TH_NUM_CHAN-1:0] thresh_o,
    output th_types_pkg::chan_mask_t                   thresh_wr_o,
    output th_types_pkg::chan_mask_t                   thresh_update_o
);
    import th_types_pkg::*;

    logic       th_we;
    chan_idx_t  th_chan;
    slot_idx_t  th_slot;
    threshold_t th_wdata;
    threshold_t th_rdata;
    chan_mask_t upd_req;
    chan_mask_t busy_mask;
    logic       period_we;
    period_t    period_wdata;
    period_t    period;
    chan_idx_t  rd_chan;
    slot_idx_t  rd_slot;
    threshold_t rd_data;

    wb_reg_decoder u_decoder (
        .wb_clk         (wb_clk),
        .rst_n_i        (rst_n_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .th_we_o        (th_we),
        .th_chan_o      (th_chan),
        .th_slot_o      (th_slot),
        .th_wdata_o     (th_wdata),
        .th_rdata_i     (th_rdata),
        .upd_req_o      (upd_req),
        .busy_mask_i    (busy_mask),
        .period_we_o    (period_we),
        .period_wdata_o (period_wdata),
        .period_i       (period)
    );

    // bus writes and bus readback share the decoded channel and slot
    threshold_bank u_bank (
        .wb_clk      (wb_clk),
        .rst_n_i     (rst_n_i),
        .we_i        (th_we),
        .wr_chan_i   (th_chan),
        .wr_slot_i   (th_slot),
        .wdata_i     (th_wdata),
        .bus_chan_i  (th_chan),
        .bus_slot_i  (th_slot),
        .bus_rdata_o (th_rdata),
        .rd_chan_i   (rd_chan),
        .rd_slot_i   (rd_slot),
        .rd_data_o   (rd_data)
    );

    update_sequencer u_sequencer (
        .wb_clk          (wb_clk),
        .rst_n_i         (rst_n_i),
        .upd_req_i       (upd_req),
        .rd_chan_o       (rd_chan),
        .rd_slot_o       (rd_slot),
        .rd_data_i       (rd_data),
        .busy_mask_o     (busy_mask),
        .thresh_o        (thresh_o),
        .thresh_wr_o     (thresh_wr_o),
        .thresh_update_o (thresh_update_o)
    );

    scaler_timer u_timer (
        .wb_clk         (wb_clk),
        .rst_n_i        (rst_n_i),
        .period_we_i    (period_we),
        .period_wdata_i (period_wdata),
        .period_o       (period),
        .scal_tick_o    (scal_tick_o),
        .scal_rst_o     (scal_rst_o)
    );

endmodule

// ==== bench/wb_thresholds_assert.sv ====
`timescale 1ns/1ps

module wb_thresholds_assert (
    input logic                     wb_clk,
    input logic                     rst_n_i,
    input logic                     cyc_i,
    input logic                     stb_i,
    input logic                     ack_i,
    input th_types_pkg::chan_mask_t wr_i,
    input th_types_pkg::chan_mask_t update_i
);

    // ack answers a strobe seen on the previous edge and is never held
    ack_follows_stb: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        ack_i |-> $past(cyc_i && stb_i) && !$past(ack_i))
        else $error("bus acknowledge without a strobe, or longer than one cycle");

    one_channel_strobes: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        $onehot0(wr_i))
        else $error("more than one channel strobed in the same cycle");

    // the update pulse closes a run of four strobes on its own channel
    update_after_stream: assert property (@(posedge wb_clk) disable iff (!rst_n_i)
        |update_i |-> $past(wr_i, 1) == update_i && $past(wr_i, 2) == update_i &&
                      $past(wr_i, 3) == update_i && $past(wr_i, 4) == update_i)
        else $error("update pulse does not follow four strobes of its channel");

endmodule

bind wb_thresholds wb_thresholds_assert u_assert (
    .wb_clk   (wb_clk),
    .rst_n_i  (rst_n_i),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .ack_i    (wb_ack_o),
    .wr_i     (thresh_wr_o),
    .update_i (thresh_update_o)
);

// ==== bench/wb_thresholds_tb.sv ====
`timescale 1ns/1ps
`include "wb_thresholds_settings.svh"

module wb_thresholds_tb;
    import th_types_pkg::*;
    import wb_map_pkg::*;

    localparam int ROWS = 8;

    logic                             wb_clk = 1'b0;
    logic                             rst_n;
    logic                             wb_cyc;
    logic                             wb_stb;
    logic                             wb_we;
    wb_adr_t                          wb_adr;
    wb_data_t                         wb_dat_w;
    wb_data_t                         wb_dat_r;
    logic                             wb_ack;
    logic                             scal_tick;
    logic                             scal_rst;
    threshold_t [`TH_NUM_CHAN-1:0]    thresh;
    chan_mask_t                       thresh_wr;
    chan_mask_t                       thresh_update;

    int         cycle = 0;
    int         limit_cycles = 0;
    logic       verdict_done = 1'b0;
    period_t    per;
    threshold_t exp_th [`TH_NUM_CHAN][`TH_NUM_SLOT];

    int         strobe_cyc [$];
    chan_mask_t strobe_mask [$];
    threshold_t strobe_val [$];
    int         upd_cyc [$];
    chan_mask_t upd_mask [$];
    int         tick_cyc [$];
    int         rst_cyc [$];

    // the expected readback keeps the low 18 bits of the written word
    string    row_name [ROWS] = '{"th_c0_s0", "th_c0_s1", "th_c0_s2", "th_c0_s3",
                                  "th_c1_s0", "th_c1_s1", "th_c1_s2", "th_c1_s3"};
    wb_adr_t  row_adr  [ROWS] = '{12'h000, 12'h004, 12'h008, 12'h00C,
                                  12'h200, 12'h204, 12'h208, 12'h20C};
    wb_data_t row_wdat [ROWS] = '{32'h0000_1234, 32'hFFFF_FFFF, 32'h0004_0001, 32'h0002_AAAA,
                                  32'h0001_5555, 32'hDEAD_BEEF, 32'h0000_0000, 32'h0003_FFFE};
    wb_data_t row_exp  [ROWS] = '{32'h0000_1234, 32'h0003_FFFF, 32'h0000_0001, 32'h0002_AAAA,
                                  32'h0001_5555, 32'h0001_BEEF, 32'h0000_0000, 32'h0003_FFFE};

    wb_thresholds DUT (
        .wb_clk          (wb_clk),
        .rst_n_i         (rst_n),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_dat_i        (wb_dat_w),
        .wb_dat_o        (wb_dat_r),
        .wb_ack_o        (wb_ack),
        .scal_tick_o     (scal_tick),
        .scal_rst_o      (scal_rst),
        .thresh_o        (thresh),
        .thresh_wr_o     (thresh_wr),
        .thresh_update_o (thresh_update)
    );

    always #50 wb_clk = ~wb_clk;

    always @(posedge wb_clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////
    // output monitors sample in the middle of the cycle
    ////////////////////////////////////////////////////////////

    always @(negedge wb_clk) begin
        if (rst_n) begin
            if (|thresh_wr) begin
                strobe_cyc.push_back(cycle);
                strobe_mask.push_back(thresh_wr);
                strobe_val.push_back(thresh_wr[1] ? thresh[1] : thresh[0]);
            end
            if (|thresh_update) begin
                upd_cyc.push_back(cycle);
                upd_mask.push_back(thresh_update);
            end
            if (scal_tick) tick_cyc.push_back(cycle);
            if (scal_rst) rst_cyc.push_back(cycle);
        end
    end

    task automatic abort_run(input string why);
        verdict_done = 1'b1;
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_threshold(input string name, input threshold_t exp,
                                   input threshold_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input chan_mask_t exp, input chan_mask_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic clear_monitors();
        strobe_cyc.delete();
        strobe_mask.delete();
        strobe_val.delete();
        upd_cyc.delete();
        upd_mask.delete();
        tick_cyc.delete();
        rst_cyc.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // bus master
    ////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        waited = 0;
        @(posedge wb_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(negedge wb_clk);
            waited++;
            if (waited > 8) abort_run("bus cycle was never acknowledged");
        end while (wb_ack !== 1'b1);
        rdata = wb_dat_r;
        @(posedge wb_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input wb_adr_t adr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input wb_adr_t adr, output wb_data_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic wait_updates(input int count);
        while (upd_cyc.size() < count) @(negedge wb_clk);
    endtask

    // one channel strobes four times in consecutive cycles and then pulses its update
    task automatic check_stream(input string name, input int first, input chan_idx_t ch,
                                input int upd_idx);
        chan_mask_t ch_mask;
        ch_mask = chan_mask_t'(1 << ch);
        for (int s = 0; s < `TH_NUM_SLOT; s++) begin
            check_mask(name, ch_mask, strobe_mask[first + s]);
            check_threshold(name, exp_th[ch][s], strobe_val[first + s]);
            check_word(name, wb_data_t'(strobe_cyc[first] + s),
                       wb_data_t'(strobe_cyc[first + s]));
        end
        check_mask(name, ch_mask, upd_mask[upd_idx]);
        check_word(name, wb_data_t'(strobe_cyc[first + 3] + 1), wb_data_t'(upd_cyc[upd_idx]));
    endtask

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge wb_clk);
        abort_run("timeout: the tests did not finish within the expected number of cycles");
    end

    initial begin : main
        wb_data_t rd;
        wb_data_t val;
        rst_n    <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        void'($urandom(75));
        per = period_t'(200 + ($urandom % 313));
        limit_cycles = ROWS * 20 + 4 * ((int'(per) > `TH_DEFAULT_PERIOD) ?
                                        int'(per) : `TH_DEFAULT_PERIOD);
        repeat (2) @(posedge wb_clk);
        rst_n <= 1'b1;

        // state after reset
        bus_read(CTRL_PERIOD, rd);
        check_word("reset_period", wb_data_t'(`TH_DEFAULT_PERIOD), rd);
        for (int i = 0; i < ROWS; i++) begin
            bus_read(row_adr[i], rd);
            check_word({"reset_", row_name[i]}, '0, rd);
        end
        bus_read(CTRL_STATUS, rd);
        check_word("reset_status", '0, rd);
        check_word("reset_strobes", '0, wb_data_t'(strobe_cyc.size() + upd_cyc.size() +
                                                   tick_cyc.size() + rst_cyc.size()));

        for (int i = 0; i < ROWS; i++) begin
            bus_write(row_adr[i], row_wdat[i]);
            exp_th[row_adr[i][9]][row_adr[i][3:2]] = threshold_t'(row_exp[i]);
        end
        for (int i = 0; i < ROWS; i++) begin
            bus_read(row_adr[i], rd);
            check_word(row_name[i], row_exp[i], rd);
        end

        clear_monitors();
        bus_write(CTRL_UPDATE, 32'h2);
        wait_updates(1);
        check_word("commit_c1_strobes", 32'd4, wb_data_t'(strobe_cyc.size()));
        check_stream("commit_c1", 0, 1'b1, 0);

        clear_monitors();
        bus_write(CTRL_UPDATE, 32'h3);
        bus_read(CTRL_STATUS, rd);
        if (rd[`TH_NUM_CHAN-1:0] == '0) abort_run("status read zero during a stream");
        wait_updates(2);
        check_word("commit_both_strobes", 32'd8, wb_data_t'(strobe_cyc.size()));
        check_stream("commit_both_c0", 0, 1'b0, 0);
        check_stream("commit_both_c1", 4, 1'b1, 1);
        bus_read(CTRL_STATUS, rd);
        check_mask("status_idle", '0, chan_mask_t'(rd));

        clear_monitors();
        bus_write(CTRL_PERIOD, wb_data_t'(per));
        while (tick_cyc.size() > 0 && tick_cyc[0] < rst_cyc[0]) void'(tick_cyc.pop_front());
        while (tick_cyc.size() < 3) @(negedge wb_clk);
        check_word("scaler_rst_count", 32'd1, wb_data_t'(rst_cyc.size()));
        check_word("tick_first", wb_data_t'(per), wb_data_t'(tick_cyc[0] - rst_cyc[0]));
        check_word("tick_second", wb_data_t'(per), wb_data_t'(tick_cyc[1] - tick_cyc[0]));
        check_word("tick_third", wb_data_t'(per), wb_data_t'(tick_cyc[2] - tick_cyc[1]));
        bus_read(CTRL_PERIOD, rd);
        check_word("period_readback", wb_data_t'(per), rd);

        // random thresholds on channel 0
        for (int s = 0; s < `TH_NUM_SLOT; s++) begin
            val = $urandom;
            bus_write(wb_adr_t'(s * 4), val);
            exp_th[0][s] = threshold_t'(val);
        end
        clear_monitors();
        bus_write(CTRL_UPDATE, 32'h1);
        wait_updates(1);
        check_word("random_c0_strobes", 32'd4, wb_data_t'(strobe_cyc.size()));
        check_stream("random_c0", 0, 1'b0, 0);

        verdict_done = 1'b1;
        $display("*** PASSED ***");
        $finish;
    end

    final begin
        if (!verdict_done) begin
            $display("*** FAILED ***");
        end
    end

endmodule

// ==== wb_thresholds.f ====
+incdir+include
design/th_types_pkg.sv
design/wb_map_pkg.sv
design/wb_reg_decoder.sv
design/threshold_bank.sv
design/update_sequencer.sv
design/scaler_timer.sv
design/wb_thresholds.sv
bench/wb_thresholds_assert.sv
bench/wb_thresholds_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f wb_thresholds.f --top-module wb_thresholds_tb -o wb_thresholds_sim &&
./obj_dir/wb_thresholds_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
